//--- src/aib_params.svh
`ifndef AIB_PARAMS_SVH
`define AIB_PARAMS_SVH

// at least 2 flops per synchronizer
`define AIB_SYNC_STAGES 2

// number of synchronized handshake inputs
`define AIB_NUM_SYNC 11

// ==================================================
// bit positions inside the synchronizer vector
// ==================================================
`define AIB_SB_CONFIG_DONE          0
`define AIB_SB_REMOTE_OSC_EN        1
`define AIB_SB_REMOTE_TX_LOCK_REQ   2
`define AIB_SB_RX_LOCK_REQ          3
`define AIB_SB_RX_DLL_LOCK          4
`define AIB_SB_REMOTE_TX_CAL_DONE   5
`define AIB_SB_REMOTE_RX_LOCK_REQ   6
`define AIB_SB_TX_LOCK_REQ          7
`define AIB_SB_TX_CAL_DONE          8
`define AIB_SB_REMOTE_RX_DLL_LOCK   9
`define AIB_SB_REMOTE_RX_EN         10

`endif

//--- src/aib_ms_pkg.sv
`include "aib_params.svh"

package aib_ms_pkg;

    // one synchronizer stage across all handshake inputs
    typedef logic [`AIB_NUM_SYNC-1:0] sync_vec_t;

    // ==================================================
    // sequencer states
    // ==================================================
    typedef enum logic [1:0] {
        wait_osc_rdy   = 2'd0,
        osc_xfer_en    = 2'd1,
        osc_xfer_alive = 2'd2
    } osc_state_t;

    typedef enum logic [2:0] {
        wait_rx_req          = 3'd0,
        wait_remote_dcc_done = 3'd1,
        send_dll_lock_req    = 3'd2,
        dll_locked           = 3'd3,
        rx_xfer_en           = 3'd4
    } rx_cal_state_t;

    typedef enum logic [2:0] {
        wait_tx_req          = 3'd0,
        send_dcc_cal_req     = 3'd1,
        wait_remote_dll_lock = 3'd2,
        wait_remote_rx_en    = 3'd3,
        tx_xfer_en           = 3'd4
    } tx_cal_state_t;

endpackage

//--- src/aib_ms_sync_bank.sv
`include "aib_params.svh"

module aib_ms_sync_bank (
    input  logic osc_clk,
    input  logic ms_reset_n_sync,
    input  logic i_config_done,
    input  logic i_remote_osc_transfer_en,
    input  logic i_remote_tx_dcc_dll_lock_req,
    input  logic i_rx_dcc_dll_lock_req,
    input  logic i_rx_dll_lock_int,
    input  logic i_remote_tx_dcc_cal_done,
    input  logic i_remote_rx_dcc_dll_lock_req,
    input  logic i_tx_dcc_dll_lock_req,
    input  logic i_tx_dcc_cal_done_int,
    input  logic i_remote_rx_dll_lock,
    input  logic i_remote_rx_transfer_en,
    output logic o_config_done_s,
    output logic o_remote_osc_transfer_en_s,
    output logic o_remote_tx_dcc_dll_lock_req_s,
    output logic o_rx_dcc_dll_lock_req_s,
    output logic o_rx_dll_lock_int_s,
    output logic o_remote_tx_dcc_cal_done_s,
    output logic o_remote_rx_dcc_dll_lock_req_s,
    output logic o_tx_dcc_dll_lock_req_s,
    output logic o_tx_dcc_cal_done_int_s,
    output logic o_remote_rx_dll_lock_s,
    output logic o_remote_rx_transfer_en_s
);

    import aib_ms_pkg::*;

    sync_vec_t raw_vec;
    sync_vec_t sync_q [`AIB_SYNC_STAGES];
    sync_vec_t sync_out;

    // ==================================================
    // pack the raw inputs
    // ==================================================
    assign raw_vec[`AIB_SB_CONFIG_DONE]        = i_config_done;
    assign raw_vec[`AIB_SB_REMOTE_OSC_EN]      = i_remote_osc_transfer_en;
    assign raw_vec[`AIB_SB_REMOTE_TX_LOCK_REQ] = i_remote_tx_dcc_dll_lock_req;
    assign raw_vec[`AIB_SB_RX_LOCK_REQ]        = i_rx_dcc_dll_lock_req;
    assign raw_vec[`AIB_SB_RX_DLL_LOCK]        = i_rx_dll_lock_int;
    assign raw_vec[`AIB_SB_REMOTE_TX_CAL_DONE] = i_remote_tx_dcc_cal_done;
    assign raw_vec[`AIB_SB_REMOTE_RX_LOCK_REQ] = i_remote_rx_dcc_dll_lock_req;
    assign raw_vec[`AIB_SB_TX_LOCK_REQ]        = i_tx_dcc_dll_lock_req;
    assign raw_vec[`AIB_SB_TX_CAL_DONE]        = i_tx_dcc_cal_done_int;
    assign raw_vec[`AIB_SB_REMOTE_RX_DLL_LOCK] = i_remote_rx_dll_lock;
    assign raw_vec[`AIB_SB_REMOTE_RX_EN]       = i_remote_rx_transfer_en;

    always_ff @(posedge osc_clk or negedge ms_reset_n_sync) begin
        if (!ms_reset_n_sync) begin
            for (int i = 0; i < `AIB_SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= raw_vec; // first stage may go metastable
            for (int i = 1; i < `AIB_SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign sync_out = sync_q[`AIB_SYNC_STAGES-1];

    // ==================================================
    // unpack the synchronized levels
    // ==================================================
    assign o_config_done_s                = sync_out[`AIB_SB_CONFIG_DONE];
    assign o_remote_osc_transfer_en_s     = sync_out[`AIB_SB_REMOTE_OSC_EN];
    assign o_remote_tx_dcc_dll_lock_req_s = sync_out[`AIB_SB_REMOTE_TX_LOCK_REQ];
    assign o_rx_dcc_dll_lock_req_s        = sync_out[`AIB_SB_RX_LOCK_REQ];
    assign o_rx_dll_lock_int_s            = sync_out[`AIB_SB_RX_DLL_LOCK];
    assign o_remote_tx_dcc_cal_done_s     = sync_out[`AIB_SB_REMOTE_TX_CAL_DONE];
    assign o_remote_rx_dcc_dll_lock_req_s = sync_out[`AIB_SB_REMOTE_RX_LOCK_REQ];
    assign o_tx_dcc_dll_lock_req_s        = sync_out[`AIB_SB_TX_LOCK_REQ];
    assign o_tx_dcc_cal_done_int_s        = sync_out[`AIB_SB_TX_CAL_DONE];
    assign o_remote_rx_dll_lock_s         = sync_out[`AIB_SB_REMOTE_RX_DLL_LOCK];
    assign o_remote_rx_transfer_en_s      = sync_out[`AIB_SB_REMOTE_RX_EN];

endmodule

//--- src/aib_ms_osc_seq.sv
module aib_ms_osc_seq (
    input  logic osc_clk,
    input  logic ms_reset_n_sync,
    input  logic i_config_done_s,
    input  logic i_remote_osc_en_s,
    output logic o_osc_transfer_en,
    output logic o_osc_transfer_alive,
    output logic o_cal_allowed
);

    import aib_ms_pkg::*;

    osc_state_t osc_state;
    osc_state_t osc_next;

    // ==================================================
    // oscillator transfer FSM
    // ==================================================
    always_comb begin
        osc_next = osc_state;
        if (!i_config_done_s) begin
            osc_next = wait_osc_rdy; // config done low restarts the sequence
        end else begin
            case (osc_state)
                wait_osc_rdy: begin
                    osc_next = osc_xfer_en;
                end
                osc_xfer_en: begin
                    if (i_remote_osc_en_s) begin
                        osc_next = osc_xfer_alive;
                    end
                end
                osc_xfer_alive: begin
                    osc_next = osc_xfer_alive;
                end
                default: begin
                    osc_next = wait_osc_rdy;
                end
            endcase
        end
    end

    always_ff @(posedge osc_clk or negedge ms_reset_n_sync) begin
        if (!ms_reset_n_sync) begin
            osc_state            <= wait_osc_rdy;
            o_osc_transfer_en    <= 1'b0;
            o_osc_transfer_alive <= 1'b0;
        end else begin
            osc_state            <= osc_next;
            o_osc_transfer_en    <= (osc_state == osc_xfer_en) |
                                    (o_osc_transfer_en & (osc_state != wait_osc_rdy));
            o_osc_transfer_alive <= (osc_state == osc_xfer_alive) |
                                    (o_osc_transfer_alive & (osc_state != wait_osc_rdy));
        end
    end

    // shared gate for both calibration FSMs
    assign o_cal_allowed = o_osc_transfer_alive & i_config_done_s;

endmodule

//--- src/aib_ms_rx_cal.sv
module aib_ms_rx_cal (
    input  logic osc_clk,
    input  logic ms_reset_n_sync,
    input  logic i_cal_allowed,
    input  logic i_remote_tx_lock_req_s,
    input  logic i_rx_lock_req_s,
    input  logic i_remote_tx_cal_done_s,
    input  logic i_rx_dll_lock_s,
    output logic o_rx_async_rst,
    output logic o_rx_dll_lock_req,
    output logic o_rx_dll_lock,
    output logic o_rx_transfer_en
);

    import aib_ms_pkg::*;

    rx_cal_state_t rx_state;
    rx_cal_state_t rx_next;
    logic          any_req;
    logic          both_req;
    logic          in_wait;

    assign any_req  = i_remote_tx_lock_req_s | i_rx_lock_req_s;
    assign both_req = i_remote_tx_lock_req_s & i_rx_lock_req_s;
    assign in_wait  = (rx_state == wait_rx_req);

    // ==================================================
    // receive calibration FSM
    // ==================================================
    always_comb begin
        rx_next = rx_state;
        case (rx_state)
            wait_rx_req: begin
                if (i_cal_allowed && any_req) begin
                    rx_next = wait_remote_dcc_done;
                end
            end
            wait_remote_dcc_done: begin
                if (i_remote_tx_cal_done_s) begin
                    rx_next = send_dll_lock_req;
                end
            end
            send_dll_lock_req: begin
                if (i_rx_dll_lock_s) begin
                    rx_next = dll_locked;
                end
            end
            dll_locked: begin
                rx_next = rx_xfer_en; // single cycle pass-through
            end
            rx_xfer_en: begin
                if (!both_req) begin
                    rx_next = wait_rx_req;
                end
            end
            default: begin
                rx_next = wait_rx_req;
            end
        endcase
    end

    always_ff @(posedge osc_clk or negedge ms_reset_n_sync) begin
        if (!ms_reset_n_sync) begin
            rx_state <= wait_rx_req;
        end else begin
            rx_state <= rx_next;
        end
    end

    // ==================================================
    // registered flags set in their state and cleared in wait
    // ==================================================
    always_ff @(posedge osc_clk or negedge ms_reset_n_sync) begin
        if (!ms_reset_n_sync) begin
            o_rx_async_rst    <= 1'b0;
            o_rx_dll_lock_req <= 1'b0;
            o_rx_dll_lock     <= 1'b0;
            o_rx_transfer_en  <= 1'b0;
        end else begin
            o_rx_async_rst    <= !in_wait;
            o_rx_dll_lock_req <= (rx_state == send_dll_lock_req) | (o_rx_dll_lock_req & !in_wait);
            o_rx_dll_lock     <= (rx_state == dll_locked) | (o_rx_dll_lock & !in_wait);
            o_rx_transfer_en  <= (rx_state == rx_xfer_en) | (o_rx_transfer_en & !in_wait);
        end
    end

endmodule

//--- src/aib_ms_tx_cal.sv
module aib_ms_tx_cal (
    input  logic osc_clk,
    input  logic ms_reset_n_sync,
    input  logic i_cal_allowed,
    input  logic i_remote_rx_lock_req_s,
    input  logic i_tx_lock_req_s,
    input  logic i_tx_cal_done_s,
    input  logic i_remote_rx_dll_lock_s,
    input  logic i_remote_rx_en_s,
    output logic o_tx_async_rst,
    output logic o_tx_dcc_cal_req,
    output logic o_tx_dcc_cal_done,
    output logic o_tx_transfer_en
);

    import aib_ms_pkg::*;

    tx_cal_state_t tx_state;
    tx_cal_state_t tx_next;
    logic          both_req;
    logic          in_wait;

    assign both_req = i_remote_rx_lock_req_s & i_tx_lock_req_s;
    assign in_wait  = (tx_state == wait_tx_req);

    // ==================================================
    // transmit calibration FSM
    // ==================================================
    always_comb begin
        tx_next = tx_state;
        case (tx_state)
            wait_tx_req: begin
                if (i_cal_allowed && both_req) begin
                    tx_next = send_dcc_cal_req;
                end
            end
            send_dcc_cal_req: begin
                if (i_tx_cal_done_s) begin
                    tx_next = wait_remote_dll_lock;
                end
            end
            wait_remote_dll_lock: begin
                if (i_remote_rx_dll_lock_s) begin
                    tx_next = wait_remote_rx_en;
                end
            end
            wait_remote_rx_en: begin
                if (i_remote_rx_en_s) begin
                    tx_next = tx_xfer_en;
                end
            end
            tx_xfer_en: begin
                if (!both_req) begin
                    tx_next = wait_tx_req; // either side withdrew its request
                end
            end
            default: begin
                tx_next = wait_tx_req;
            end
        endcase
    end

    always_ff @(posedge osc_clk or negedge ms_reset_n_sync) begin
        if (!ms_reset_n_sync) begin
            tx_state <= wait_tx_req;
        end else begin
            tx_state <= tx_next;
        end
    end

    // ==================================================
    // registered flags
    // ==================================================
    always_ff @(posedge osc_clk or negedge ms_reset_n_sync) begin
        if (!ms_reset_n_sync) begin
            o_tx_async_rst    <= 1'b0;
            o_tx_dcc_cal_req  <= 1'b0;
            o_tx_dcc_cal_done <= 1'b0;
            o_tx_transfer_en  <= 1'b0;
        end else begin
            o_tx_async_rst    <= !in_wait;
            o_tx_dcc_cal_req  <= (tx_state == send_dcc_cal_req) | (o_tx_dcc_cal_req & !in_wait);
            o_tx_dcc_cal_done <= (tx_state == wait_remote_dll_lock) |
                                 (o_tx_dcc_cal_done & !in_wait); // local cal seen
            o_tx_transfer_en  <= (tx_state == tx_xfer_en) | (o_tx_transfer_en & !in_wait);
        end
    end

endmodule

//--- src/aib_ms_calib_top.sv
module aib_ms_calib_top (
    input  logic osc_clk,
    input  logic ms_reset_n_sync,
    input  logic i_config_done,
    input  logic i_remote_osc_transfer_en,
    input  logic i_remote_tx_dcc_dll_lock_req,
    input  logic i_rx_dcc_dll_lock_req,
    input  logic i_rx_dll_lock_int,
    input  logic i_remote_tx_dcc_cal_done,
    input  logic i_remote_rx_dcc_dll_lock_req,
    input  logic i_tx_dcc_dll_lock_req,
    input  logic i_tx_dcc_cal_done_int,
    input  logic i_remote_rx_dll_lock,
    input  logic i_remote_rx_transfer_en,
    output logic o_osc_transfer_en,
    output logic o_osc_transfer_alive,
    output logic o_rx_async_rst,
    output logic o_rx_dll_lock_req,
    output logic o_rx_dll_lock,
    output logic o_rx_transfer_en,
    output logic o_tx_async_rst,
    output logic o_tx_dcc_cal_req,
    output logic o_tx_dcc_cal_done,
    output logic o_tx_transfer_en
);

    logic config_done_s;
    logic remote_osc_en_s;
    logic remote_tx_lock_req_s;
    logic rx_lock_req_s;
    logic rx_dll_lock_s;
    logic remote_tx_cal_done_s;
    logic remote_rx_lock_req_s;
    logic tx_lock_req_s;
    logic tx_cal_done_s;
    logic remote_rx_dll_lock_s;
    logic remote_rx_en_s;
    logic cal_allowed;

    // ==================================================
    // input resynchronization
    // ==================================================
    aib_ms_sync_bank u_sync_bank (
        .osc_clk                        (osc_clk),
        .ms_reset_n_sync                (ms_reset_n_sync),
        .i_config_done                  (i_config_done),
        .i_remote_osc_transfer_en       (i_remote_osc_transfer_en),
        .i_remote_tx_dcc_dll_lock_req   (i_remote_tx_dcc_dll_lock_req),
        .i_rx_dcc_dll_lock_req          (i_rx_dcc_dll_lock_req),
        .i_rx_dll_lock_int              (i_rx_dll_lock_int),
        .i_remote_tx_dcc_cal_done       (i_remote_tx_dcc_cal_done),
        .i_remote_rx_dcc_dll_lock_req   (i_remote_rx_dcc_dll_lock_req),
        .i_tx_dcc_dll_lock_req          (i_tx_dcc_dll_lock_req),
        .i_tx_dcc_cal_done_int          (i_tx_dcc_cal_done_int),
        .i_remote_rx_dll_lock           (i_remote_rx_dll_lock),
        .i_remote_rx_transfer_en        (i_remote_rx_transfer_en),
        .o_config_done_s                (config_done_s),
        .o_remote_osc_transfer_en_s     (remote_osc_en_s),
        .o_remote_tx_dcc_dll_lock_req_s (remote_tx_lock_req_s),
        .o_rx_dcc_dll_lock_req_s        (rx_lock_req_s),
        .o_rx_dll_lock_int_s            (rx_dll_lock_s),
        .o_remote_tx_dcc_cal_done_s     (remote_tx_cal_done_s),
        .o_remote_rx_dcc_dll_lock_req_s (remote_rx_lock_req_s),
        .o_tx_dcc_dll_lock_req_s        (tx_lock_req_s),
        .o_tx_dcc_cal_done_int_s        (tx_cal_done_s),
        .o_remote_rx_dll_lock_s         (remote_rx_dll_lock_s),
        .o_remote_rx_transfer_en_s      (remote_rx_en_s)
    );

    // ==================================================
    // sequencers
    // ==================================================
    aib_ms_osc_seq u_osc_seq (
        .osc_clk              (osc_clk),
        .ms_reset_n_sync      (ms_reset_n_sync),
        .i_config_done_s      (config_done_s),
        .i_remote_osc_en_s    (remote_osc_en_s),
        .o_osc_transfer_en    (o_osc_transfer_en),
        .o_osc_transfer_alive (o_osc_transfer_alive),
        .o_cal_allowed        (cal_allowed)
    );

    aib_ms_rx_cal u_rx_cal (
        .osc_clk                (osc_clk),
        .ms_reset_n_sync        (ms_reset_n_sync),
        .i_cal_allowed          (cal_allowed),
        .i_remote_tx_lock_req_s (remote_tx_lock_req_s),
        .i_rx_lock_req_s        (rx_lock_req_s),
        .i_remote_tx_cal_done_s (remote_tx_cal_done_s),
        .i_rx_dll_lock_s        (rx_dll_lock_s),
        .o_rx_async_rst         (o_rx_async_rst),
        .o_rx_dll_lock_req      (o_rx_dll_lock_req),
        .o_rx_dll_lock          (o_rx_dll_lock),
        .o_rx_transfer_en       (o_rx_transfer_en)
    );

    aib_ms_tx_cal u_tx_cal (
        .osc_clk                (osc_clk),
        .ms_reset_n_sync        (ms_reset_n_sync),
        .i_cal_allowed          (cal_allowed),
        .i_remote_rx_lock_req_s (remote_rx_lock_req_s),
        .i_tx_lock_req_s        (tx_lock_req_s),
        .i_tx_cal_done_s        (tx_cal_done_s),
        .i_remote_rx_dll_lock_s (remote_rx_dll_lock_s),
        .i_remote_rx_en_s       (remote_rx_en_s),
        .o_tx_async_rst         (o_tx_async_rst),
        .o_tx_dcc_cal_req       (o_tx_dcc_cal_req),
        .o_tx_dcc_cal_done      (o_tx_dcc_cal_done),
        .o_tx_transfer_en       (o_tx_transfer_en)
    );

endmodule

//--- tests/tb_clock_gen.sv
module tb_clock_gen (
    output logic o_osc_clk,
    output logic o_ms_reset_n_sync
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int half_period_ns = 5;
    localparam int reset_cycles   = 3;

    initial begin
        o_osc_clk = 1'b0;
        forever #(half_period_ns) o_osc_clk = ~o_osc_clk; // 10 ns period
    end

    initial begin
        o_ms_reset_n_sync = 1'b0;
        #(2 * half_period_ns * reset_cycles);
        o_ms_reset_n_sync = 1'b1; // released on a falling edge
    end

endmodule

//--- tests/aib_ms_checker.sv
module aib_ms_checker (
    input logic osc_clk,
    input logic ms_reset_n_sync,
    input logic i_osc_transfer_en,
    input logic i_osc_transfer_alive,
    input logic i_rx_async_rst,
    input logic i_rx_dll_lock_req,
    input logic i_rx_dll_lock,
    input logic i_rx_transfer_en,
    input logic i_tx_async_rst,
    input logic i_tx_dcc_cal_req,
    input logic i_tx_dcc_cal_done,
    input logic i_tx_transfer_en
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;
    logic [7:0]  cal_flags;

    assign cal_flags = {i_tx_transfer_en, i_tx_dcc_cal_done, i_tx_dcc_cal_req, i_tx_async_rst,
                        i_rx_transfer_en, i_rx_dll_lock, i_rx_dll_lock_req, i_rx_async_rst};

    // ==================================================
    // output ordering
    // ==================================================
    alive_needs_en: assert property (@(posedge osc_clk) disable iff (!ms_reset_n_sync)
        i_osc_transfer_alive |-> i_osc_transfer_en)
    else begin
        $error("transfer alive is high while transfer enable is low");
        fail_count++;
    end

    rx_xfer_needs_lock: assert property (@(posedge osc_clk) disable iff (!ms_reset_n_sync)
        i_rx_transfer_en |-> i_rx_dll_lock)
    else begin
        $error("rx transfer enable is high without the rx DLL lock");
        fail_count++;
    end

    tx_xfer_needs_cal: assert property (@(posedge osc_clk) disable iff (!ms_reset_n_sync)
        i_tx_transfer_en |-> i_tx_dcc_cal_done)
    else begin
        $error("tx transfer enable is high without the tx cal done");
        fail_count++;
    end

    // any rising cal flag needs the link alive
    cal_rise_needs_alive: assert property (@(posedge osc_clk) disable iff (!ms_reset_n_sync)
        (|(cal_flags & ~$past(cal_flags))) |-> i_osc_transfer_alive)
    else begin
        $error("a calibration flag rose while transfer alive was low");
        fail_count++;
    end

endmodule

bind aib_ms_calib_top aib_ms_checker u_checker (
    .osc_clk              (osc_clk),
    .ms_reset_n_sync      (ms_reset_n_sync),
    .i_osc_transfer_en    (o_osc_transfer_en),
    .i_osc_transfer_alive (o_osc_transfer_alive),
    .i_rx_async_rst       (o_rx_async_rst),
    .i_rx_dll_lock_req    (o_rx_dll_lock_req),
    .i_rx_dll_lock        (o_rx_dll_lock),
    .i_rx_transfer_en     (o_rx_transfer_en),
    .i_tx_async_rst       (o_tx_async_rst),
    .i_tx_dcc_cal_req     (o_tx_dcc_cal_req),
    .i_tx_dcc_cal_done    (o_tx_dcc_cal_done),
    .i_tx_transfer_en     (o_tx_transfer_en)
);

//--- tests/tb_aib_ms_calib.sv
`include "aib_params.svh"

module tb_aib_ms_calib;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    clk_period_ns = 10;
    localparam int    margin_cycles = 50;
    localparam string cases_file    = "tests/aib_ms_cases.txt";

    logic osc_clk;
    logic ms_reset_n_sync;
    logic i_config_done;
    logic i_remote_osc_transfer_en;
    logic i_remote_tx_dcc_dll_lock_req;
    logic i_rx_dcc_dll_lock_req;
    logic i_rx_dll_lock_int;
    logic i_remote_tx_dcc_cal_done;
    logic i_remote_rx_dcc_dll_lock_req;
    logic i_tx_dcc_dll_lock_req;
    logic i_tx_dcc_cal_done_int;
    logic i_remote_rx_dll_lock;
    logic i_remote_rx_transfer_en;
    logic o_osc_transfer_en;
    logic o_osc_transfer_alive;
    logic o_rx_async_rst;
    logic o_rx_dll_lock_req;
    logic o_rx_dll_lock;
    logic o_rx_transfer_en;
    logic o_tx_async_rst;
    logic o_tx_dcc_cal_req;
    logic o_tx_dcc_cal_done;
    logic o_tx_transfer_en;
    logic [9:0] actual_out;

    string       case_name [$];
    logic [10:0] case_in   [$];
    int          case_hold [$];
    logic [9:0]  case_exp  [$];

    int     mismatch_count = 0;
    int     setup_count    = 0;
    int     total_hold     = 0;
    longint watchdog_ns    = 0;
    logic   cases_loaded   = 1'b0;

    tb_clock_gen clock_gen_i (
        .o_osc_clk         (osc_clk),
        .o_ms_reset_n_sync (ms_reset_n_sync)
    );

    aib_ms_calib_top aib_ms_calib_top_i (.*);

    assign actual_out = {o_tx_transfer_en, o_tx_dcc_cal_done, o_tx_dcc_cal_req, o_tx_async_rst,
                         o_rx_transfer_en, o_rx_dll_lock, o_rx_dll_lock_req, o_rx_async_rst,
                         o_osc_transfer_alive, o_osc_transfer_en};

    // ==================================================
    // helpers
    // ==================================================
    task automatic apply_inputs(input logic [10:0] vec);
        i_config_done                <= vec[`AIB_SB_CONFIG_DONE];
        i_remote_osc_transfer_en     <= vec[`AIB_SB_REMOTE_OSC_EN];
        i_remote_tx_dcc_dll_lock_req <= vec[`AIB_SB_REMOTE_TX_LOCK_REQ];
        i_rx_dcc_dll_lock_req        <= vec[`AIB_SB_RX_LOCK_REQ];
        i_rx_dll_lock_int            <= vec[`AIB_SB_RX_DLL_LOCK];
        i_remote_tx_dcc_cal_done     <= vec[`AIB_SB_REMOTE_TX_CAL_DONE];
        i_remote_rx_dcc_dll_lock_req <= vec[`AIB_SB_REMOTE_RX_LOCK_REQ];
        i_tx_dcc_dll_lock_req        <= vec[`AIB_SB_TX_LOCK_REQ];
        i_tx_dcc_cal_done_int        <= vec[`AIB_SB_TX_CAL_DONE];
        i_remote_rx_dll_lock         <= vec[`AIB_SB_REMOTE_RX_DLL_LOCK];
        i_remote_rx_transfer_en      <= vec[`AIB_SB_REMOTE_RX_EN];
    endtask

    task automatic load_cases(input int fd);
        string       line;
        string       name;
        logic [10:0] vin;
        int          hold;
        logic [9:0]  vexp;
        int          fields;
        int          line_no;
        line_no = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue; // blank or column notes
            end
            fields = $sscanf(line, "%s %b %d %b", name, vin, hold, vexp);
            if (fields != 4) begin
                $display("line %0d of the case file could not be read", line_no);
                setup_count++;
            end else begin
                if (hold < `AIB_SYNC_STAGES + 3) begin
                    $display("case %s on line %0d holds %0d cycles, too short to settle",
                             name, line_no, hold);
                    setup_count++;
                end
                case_name.push_back(name);
                case_in.push_back(vin);
                case_hold.push_back(hold);
                case_exp.push_back(vexp);
                total_hold += hold;
            end
        end
    endtask

    task automatic check_outputs(input string name, input logic [9:0] expected);
        assert (actual_out === expected) else begin
            $display("ERR %s expected %b actual %b", name, expected, actual_out);
            mismatch_count++;
        end
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        int fd;
        int total_errors;
        apply_inputs('0);
        fd = $fopen(cases_file, "r");
        if (fd == 0) begin
            $display("cannot open the case file %s", cases_file);
            $display("Regression failed");
            $finish;
        end else begin
            load_cases(fd);
            $fclose(fd);
            if (case_name.size() == 0) begin
                $display("no test cases found in %s", cases_file);
                setup_count++;
            end
            watchdog_ns  = longint'(total_hold + margin_cycles) * clk_period_ns;
            cases_loaded = 1'b1;

            wait (ms_reset_n_sync === 1'b1);
            @(posedge osc_clk);
            foreach (case_name[i]) begin
                apply_inputs(case_in[i]);
                repeat (case_hold[i] - 1) @(posedge osc_clk);
                @(negedge osc_clk); // outputs settled mid-cycle
                check_outputs(case_name[i], case_exp[i]);
                @(posedge osc_clk);
            end

            total_errors = mismatch_count + setup_count +
                           int'(aib_ms_calib_top_i.u_checker.fail_count);
            $display("errors: %0d mismatches, %0d case file problems, %0d assertion failures",
                     mismatch_count, setup_count, aib_ms_calib_top_i.u_checker.fail_count);
            if (total_errors == 0) begin
                $display("Regression passed");
            end else begin
                $display("Regression failed");
            end
            $finish;
        end
    end

    // watchdog sized from the summed hold counts
    initial begin
        wait (cases_loaded === 1'b1);
        #(watchdog_ns);
        $display("timeout after %0d ns, the cases did not complete", watchdog_ns);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- tests/aib_ms_cases.txt
# columns: name  inputs[10:0]  hold_cycles  expected[9:0]
# inputs 10..0: rrx_en rrx_dll tx_cal tx_req rrx_req rtx_cal rx_dll rx_req rtx_req rosc cfg
# expected 9..0: tx_xfer tx_done tx_calreq tx_rst rx_xfer rx_lock rx_lockreq rx_rst alive osc_en
reset_idle 00000000000 8 0000000000
no_config  11111111110 8 0000000000
no_config  00000000000 8 0000000000
osc_seq    00000000001 8 0000000001
osc_seq    00000000011 8 0000000011
osc_seq    00000000010 8 0000000000
osc_seq    00000000011 8 0000000011
rx_cal     00000001011 8 0000000111
rx_cal     00000001111 8 0000000111
rx_cal     00000101111 8 0000001111
rx_cal     00000111111 8 0000111111
rx_exit    00000111111 12 0000111111
rx_exit    00000000111 8 0000000111
rx_exit    00000110011 10 0000000011
rx_exit    00000000011 8 0000000011
tx_cal     00010000011 8 0000000011
tx_cal     00011000011 8 0011000011
tx_cal     00111000011 8 0111000011
tx_cal     01111000011 8 0111000011
tx_cal     11111000011 8 1111000011
tx_exit    11101000011 8 0000000011
tx_exit    00000000011 8 0000000011
shutdown   00000000000 8 0000000000

//--- vlog.f
+incdir+src
src/aib_ms_pkg.sv
src/aib_ms_sync_bank.sv
src/aib_ms_osc_seq.sv
src/aib_ms_rx_cal.sv
src/aib_ms_tx_cal.sv
src/aib_ms_calib_top.sv
tests/tb_clock_gen.sv
tests/aib_ms_checker.sv
tests/tb_aib_ms_calib.sv
